//--- verilog.f
src/mem_pkg.sv
src/dbus_if.sv
src/pmp_checker.sv
src/lane_align.sv
src/amo_alu.sv
src/mem_access_ctrl.sv
src/mem_stage.sv
sim/mem_stage_props.sv
sim/tb_mem_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module tb_mem_stage -o tb_mem_stage > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/tb_mem_stage > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with a nonzero status, see sim.log"
fi

if grep -qx "NO ERRORS" sim.log; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed, see sim.log"
exit 1

//--- sim/tb_mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage;
  import mem_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int N_RANDOM   = 200;
  // loads 30, stores 30, amo 36, pmp 192, non-memory 8
  localparam int NUM_OPS    = 30 + 30 + 36 + 192 + 8 + N_RANDOM;
  localparam int K_NONE     = 0;
  localparam int K_LOAD     = 1;
  localparam int K_STORE    = 2;
  localparam int K_AMO      = 3;

  logic              clk = 1'b0;
  logic              reset, start, is_load, is_store, is_amo, unsigned_load;
  mem_size_t         size;
  amo_op_t           amo_op;
  logic [XLEN-1:0]   addr, wdata, pmpaddr0, result, dbus_addr, dbus_wdata, dbus_rdata;
  logic [7:0]        pmpcfg0;
  logic [1:0]        priv_mode;
  logic              done, fault, dbus_valid, dbus_data_ok;
  logic [STRB_W-1:0] dbus_strobe;
  mem_size_t         dbus_size;

  logic [XLEN-1:0] mem [0:31];      // bus side memory
  logic [XLEN-1:0] shadow [0:31];   // reference copy
  logic [XLEN-1:0] pmp_addrs [4] = '{64'h20, 64'h40, 64'h44, 64'h1800};
  logic [XLEN-1:0] exp_res_q[$];
  logic            exp_flt_q[$];
  int              exp_reqs_q[$];
  int              start_cyc_q[$];
  int              req_base_q[$];
  int              cycle_cnt = 0;
  int              req_count = 0;
  int              errors = 0;
  bit              pending;
  int              wait_cnt;
  mem_size_t       req_size;        // bus size the current operation should use

  mem_stage dut (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  task automatic fail_run(input string line);
    errors++;
    $display("%s", line);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic mismatch(input string what, input logic [XLEN-1:0] got,
                          input logic [XLEN-1:0] exp);
    fail_run($sformatf("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp));
  endtask

  function automatic logic [7:0] fill_byte(input int a);
    return 8'((a * 37 + 11) ^ (a >> 5));
  endfunction

  // expected result, fault and bus request count
  // shadow memory is updated as it goes
  function automatic logic [XLEN-1:0] ref_op(input int kind, input int sz, input bit uns,
      input int op, input logic [XLEN-1:0] a, input logic [XLEN-1:0] wd,
      output logic flt, output int reqs);
    logic [XLEN-1:0] base;
    logic [XLEN-1:0] napot;
    logic [XLEN-1:0] mask;
    logic [XLEN-1:0] res;
    logic [31:0]     o;
    logic [31:0]     b;
    logic [31:0]     n;
    logic            hit;
    int              nb;
    int              idx;
    int              off;
    flt  = 1'b0;
    reqs = 0;
    res  = a;
    base  = (pmpaddr0 & 64'h003f_ffff_ffff_ffff) << 2;
    napot = pmpaddr0 & 64'h003f_ffff_ffff_f000;
    case (pmpcfg0[4:3])
      2'd1:    hit = a < base;
      2'd2:    hit = (a >= base) && (a < base + 64'd4);
      2'd3:    hit = (a >= napot) && (a < napot + 64'd4096);
      default: hit = 1'b0;
    endcase
    if (kind != K_NONE) begin
      if (hit) flt = (kind == K_LOAD) ? !pmpcfg0[0] : !pmpcfg0[1];
      else     flt = (priv_mode != PRIV_M);
    end
    idx = int'(a[7:3]);
    off = int'(a[2:0]);
    nb  = 1 << sz;
    if (kind == K_LOAD && !flt) begin
      reqs = 1;
      res  = shadow[idx] >> (8 * off);
      if (nb < 8) begin
        mask = (64'd1 << (8 * nb)) - 64'd1;
        res  = res & mask;
        if (!uns && res[8 * nb - 1])
          res = res | ~mask;
      end
    end else if (kind == K_STORE && !flt) begin
      reqs = 1;
      for (int i = 0; i < nb; i++)
        shadow[idx][8 * (off + i) +: 8] = wd[8 * i +: 8];
    end else if (kind == K_AMO && !flt) begin
      reqs = 2;   // read, then write
      o = shadow[idx][8 * off +: 32];
      b = wd[31:0];
      case (amo_op_t'(op))
        AMO_SWAP: n = b;
        AMO_ADD:  n = o + b;
        AMO_XOR:  n = o ^ b;
        AMO_AND:  n = o & b;
        AMO_OR:   n = o | b;
        AMO_MIN:  n = ($signed(o) < $signed(b)) ? o : b;
        AMO_MAX:  n = ($signed(o) > $signed(b)) ? o : b;
        AMO_MINU: n = (o < b) ? o : b;
        default:  n = (o > b) ? o : b;
      endcase
      shadow[idx][8 * off +: 32] = n;
      res = {{32{o[31]}}, o};
    end
    return res;
  endfunction

  task automatic run_op(input int kind, input int sz, input bit uns, input int op,
                        input logic [XLEN-1:0] a, input logic [XLEN-1:0] wd,
                        input bit hold_busy);
    logic [XLEN-1:0] er;
    logic            ef;
    int              nr;
    bit              got;
    is_load       = (kind == K_LOAD);
    is_store      = (kind == K_STORE);
    is_amo        = (kind == K_AMO);
    size          = mem_size_t'(sz);
    unsigned_load = uns;
    amo_op        = amo_op_t'(op);
    addr          = a;
    wdata         = wd;
    req_size      = (kind == K_AMO) ? SIZE_W : mem_size_t'(sz);  // amo is a word access
    er = ref_op(kind, sz, uns, op, a, wd, ef, nr);
    exp_res_q.push_back(er);
    exp_flt_q.push_back(ef);
    exp_reqs_q.push_back(nr);
    start_cyc_q.push_back(cycle_cnt);
    req_base_q.push_back(req_count);
    start = 1'b1;
    @(posedge clk);
    #1;
    got = done;
    if (hold_busy) begin
      addr    = ~a;   // second start lands on a busy controller
      is_load = 1'b1;
      @(posedge clk);
      #1;
      got = got || done;
    end
    start = 1'b0;
    while (!got) begin
      @(posedge clk);
      #1;
      got = done;
    end
    @(posedge clk);   // controller back in idle
    #1;
  endtask

  task automatic check_memory();
    for (int i = 0; i < 32; i++)
      assert (mem[i] === shadow[i])
        else mismatch($sformatf("memory doubleword %0d", i), mem[i], shadow[i]);
  endtask

  // memory model answers 1 to 4 cycles after each request
  always begin
    @(posedge clk);
    #1;
    if (dbus_data_ok) begin
      dbus_data_ok = 1'b0;
      pending      = 1'b0;
    end
    if (reset) begin
      pending = 1'b0;
    end else if (dbus_valid && !pending) begin
      assert (dbus_size === req_size)
        else mismatch("bus size", 64'(dbus_size), 64'(req_size));
      pending  = 1'b1;
      wait_cnt = $urandom_range(1, 4);
      req_count++;
    end else if (dbus_valid) begin
      wait_cnt--;
      if (wait_cnt == 0) begin
        dbus_rdata = mem[dbus_addr[7:3]];
        for (int i = 0; i < STRB_W; i++)
          if (dbus_strobe[i])
            mem[dbus_addr[7:3]][8 * i +: 8] = dbus_wdata[8 * i +: 8];
        dbus_data_ok = 1'b1;
      end
    end
  end

  always begin : compare
    logic [XLEN-1:0] er;
    logic            ef;
    int              nr;
    int              sc;
    int              rb;
    @(posedge clk);
    #1;
    if (!reset && done) begin
      assert (exp_res_q.size() > 0) else fail_run("done pulse with no operation outstanding");
      er = exp_res_q.pop_front();
      ef = exp_flt_q.pop_front();
      nr = exp_reqs_q.pop_front();
      sc = start_cyc_q.pop_front();
      rb = req_base_q.pop_front();
      assert (result === er) else mismatch("result", result, er);
      assert (fault === ef) else mismatch("fault", 64'(fault), 64'(ef));
      assert (req_count - rb == nr)
        else mismatch("bus request count", 64'(req_count - rb), 64'(nr));
      if (nr == 0)
        assert (cycle_cnt - sc == 1)
          else mismatch("cycles to done", 64'(cycle_cnt - sc), 64'd1);
    end
  end

  initial begin
    #((NUM_OPS * 40 + 20) * CLK_PERIOD);
    fail_run($sformatf("timeout: %0d operations did not finish in time", NUM_OPS));
  end

  initial begin
    int              k;
    int              s;
    logic [XLEN-1:0] a;
    void'($urandom(3));
    reset         = 1'b1;
    start         = 1'b0;
    is_load       = 1'b0;
    is_store      = 1'b0;
    is_amo        = 1'b0;
    unsigned_load = 1'b0;
    size          = SIZE_B;
    amo_op        = AMO_SWAP;
    addr          = '0;
    wdata         = '0;
    pmpaddr0      = '0;
    pmpcfg0       = '0;
    priv_mode     = PRIV_M;
    dbus_data_ok  = 1'b0;
    dbus_rdata    = '0;
    for (int i = 0; i < 32; i++) begin
      for (int j = 0; j < 8; j++)
        mem[i][8 * j +: 8] = fill_byte(8 * i + j);
      shadow[i] = mem[i];
    end
    repeat (10) @(posedge clk);
    #1;
    assert (!done && !fault && !dbus_valid)
      else fail_run("done, fault or dbus_valid not low during reset");
    reset = 1'b0;
    @(posedge clk);
    #1;

    for (int sz = 0; sz < 4; sz++)
      for (int off = 0; off < 8; off += (1 << sz))
        for (int u = 0; u < 2; u++)
          run_op(K_LOAD, sz, u[0], 0, 64'h40 + 64'(off), '0, 1'b0);

    for (int sz = 0; sz < 4; sz++)
      for (int off = 0; off < 8; off += (1 << sz)) begin
        run_op(K_STORE, sz, 1'b0, 0, 64'h80 + 64'(off), {$urandom, $urandom}, 1'b0);
        run_op(K_LOAD, 3, 1'b0, 0, 64'h80, '0, 1'b0);
        check_memory();
      end

    for (int op = 0; op < 9; op++)
      for (int off = 0; off < 8; off += 4) begin
        run_op(K_AMO, 2, 1'b0, op, 64'hc0 + 64'(off), {$urandom, $urandom}, 1'b0);
        run_op(K_LOAD, 2, 1'b0, 0, 64'hc0 + 64'(off), '0, 1'b0);
      end
    check_memory();

    pmpaddr0 = 64'h10;   // tor top and na4 at 0x40, napot region at 0
    for (int m = 0; m < 4; m++)
      for (int p = 0; p < 2; p++)
        for (int perm = 1; perm < 3; perm++) begin
          pmpcfg0   = 8'((m << 3) | perm);
          priv_mode = p[0] ? PRIV_M : 2'd0;
          foreach (pmp_addrs[i])
            for (int kd = K_LOAD; kd <= K_AMO; kd++)
              run_op(kd, 2, 1'b0, $urandom_range(0, 8), pmp_addrs[i],
                     {$urandom, $urandom}, 1'b0);
        end
    pmpcfg0   = '0;
    priv_mode = PRIV_M;
    check_memory();

    for (int i = 0; i < 8; i++)
      run_op(K_NONE, 0, 1'b0, 0, {$urandom, $urandom}, '0, i[0]);

    // mixed traffic under random latency
    for (int i = 0; i < N_RANDOM; i++) begin
      k = $urandom_range(0, 3);
      s = (k == K_AMO) ? 2 : $urandom_range(0, 3);
      a = 64'($urandom_range(0, 255));
      a = a & ~((64'd1 << s) - 64'd1);
      run_op(k, s, 1'($urandom), $urandom_range(0, 8), a, {$urandom, $urandom},
             $urandom_range(0, 3) == 0);
    end
    check_memory();

    assert (dut.props.assert_fails == 0) else fail_run("a bound bus or completion property failed");
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/mem_stage_props.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage_props (
  input logic                       clk,
  input logic                       reset,
  input logic                       done,
  input logic                       fault,
  input logic                       dbus_valid,
  input logic                       dbus_data_ok,
  input logic [mem_pkg::XLEN-1:0]   dbus_addr,
  input logic [mem_pkg::XLEN-1:0]   dbus_wdata,
  input logic [mem_pkg::STRB_W-1:0] dbus_strobe,
  input mem_pkg::mem_size_t         dbus_size
);
  int assert_fails = 0;

  // request held until memory answers
  request_stable: assert property (@(posedge clk) disable iff (reset)
      dbus_valid && !dbus_data_ok |=> dbus_valid && $stable(dbus_addr) &&
        $stable(dbus_strobe) && $stable(dbus_wdata) && $stable(dbus_size))
    else begin
      assert_fails++;
      $error("bus request changed before data_ok");
    end

  done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else begin
      assert_fails++;
      $error("done high for more than one cycle");
    end

  fault_no_bus: assert property (@(posedge clk) disable iff (reset)
      fault |-> done && !dbus_valid)
    else begin
      assert_fails++;
      $error("fault reported with a bus request or without done");
    end

endmodule

bind mem_stage mem_stage_props props (
  .clk          (clk),
  .reset        (reset),
  .done         (done),
  .fault        (fault),
  .dbus_valid   (dbus_valid),
  .dbus_data_ok (dbus_data_ok),
  .dbus_addr    (dbus_addr),
  .dbus_wdata   (dbus_wdata),
  .dbus_strobe  (dbus_strobe),
  .dbus_size    (dbus_size)
);

`default_nettype wire

//--- src/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       start,
  input  logic                       is_load,
  input  logic                       is_store,
  input  logic                       is_amo,
  input  logic                       unsigned_load,
  input  mem_pkg::mem_size_t         size,
  input  mem_pkg::amo_op_t           amo_op,
  input  logic [mem_pkg::XLEN-1:0]   addr,
  input  logic [mem_pkg::XLEN-1:0]   wdata,
  input  logic [mem_pkg::XLEN-1:0]   pmpaddr0,
  input  logic [7:0]                 pmpcfg0,
  input  logic [1:0]                 priv_mode,
  output logic                       done,
  output logic                       fault,
  output logic [mem_pkg::XLEN-1:0]   result,
  output logic                       dbus_valid,
  output logic [mem_pkg::XLEN-1:0]   dbus_addr,
  output logic [mem_pkg::XLEN-1:0]   dbus_wdata,
  output logic [mem_pkg::STRB_W-1:0] dbus_strobe,
  output mem_pkg::mem_size_t         dbus_size,
  input  logic                       dbus_data_ok,
  input  logic [mem_pkg::XLEN-1:0]   dbus_rdata
);
  import mem_pkg::*;

  logic              access_fault;
  logic [STRB_W-1:0] store_strobe;
  logic [XLEN-1:0]   store_data;
  logic [XLEN-1:0]   load_value;
  logic [31:0]       amo_new;
  logic [XLEN-1:0]   saved_addr;
  mem_size_t         saved_size;
  logic              saved_unsigned;
  amo_op_t           saved_op;
  logic [XLEN-1:0]   saved_wdata;
  logic [XLEN-1:0]   old_word;

  dbus_if bus ();

  mem_access_ctrl u_ctrl (
    .clk            (clk),
    .reset          (reset),
    .start          (start),
    .is_load        (is_load),
    .is_store       (is_store),
    .is_amo         (is_amo),
    .size           (size),
    .unsigned_load  (unsigned_load),
    .amo_op         (amo_op),
    .addr           (addr),
    .wdata          (wdata),
    .access_fault   (access_fault),
    .store_strobe   (store_strobe),
    .store_data     (store_data),
    .load_value     (load_value),
    .amo_new        (amo_new),
    .saved_addr     (saved_addr),
    .saved_size     (saved_size),
    .saved_unsigned (saved_unsigned),
    .saved_op       (saved_op),
    .saved_wdata    (saved_wdata),
    .old_word       (old_word),
    .bus            (bus.master),
    .done           (done),
    .fault          (fault),
    .result         (result)
  );

  // checked on the start cycle inputs
  pmp_checker u_pmp (
    .addr         (addr),
    .is_write     (is_store || is_amo),
    .pmpcfg0      (pmpcfg0),
    .pmpaddr0     (pmpaddr0),
    .priv_mode    (priv_mode),
    .access_fault (access_fault)
  );

  // both sides work on the registered operation
  lane_align u_lane (
    .addr          (saved_addr),
    .size          (saved_size),
    .wdata         (saved_wdata),
    .rdata         (bus.rdata),
    .unsigned_load (saved_unsigned),
    .store_strobe  (store_strobe),
    .store_data    (store_data),
    .load_value    (load_value)
  );

  amo_alu u_amo (
    .op       (saved_op),
    .old_word (old_word),
    .operand  (saved_wdata),
    .amo_new  (amo_new)
  );

  // bus out to plain ports
  assign dbus_valid   = bus.valid;
  assign dbus_addr    = bus.addr;
  assign dbus_wdata   = bus.wdata;
  assign dbus_strobe  = bus.strobe;
  assign dbus_size    = bus.size;
  assign bus.data_ok  = dbus_data_ok;
  assign bus.rdata    = dbus_rdata;

endmodule

`default_nettype wire

//--- src/mem_access_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access_ctrl (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       start,
  input  logic                       is_load,
  input  logic                       is_store,
  input  logic                       is_amo,
  input  mem_pkg::mem_size_t         size,
  input  logic                       unsigned_load,
  input  mem_pkg::amo_op_t           amo_op,
  input  logic [mem_pkg::XLEN-1:0]   addr,
  input  logic [mem_pkg::XLEN-1:0]   wdata,
  input  logic                       access_fault,
  input  logic [mem_pkg::STRB_W-1:0] store_strobe,
  input  logic [mem_pkg::XLEN-1:0]   store_data,
  input  logic [mem_pkg::XLEN-1:0]   load_value,
  input  logic [31:0]                amo_new,
  output logic [mem_pkg::XLEN-1:0]   saved_addr,
  output mem_pkg::mem_size_t         saved_size,
  output logic                       saved_unsigned,
  output mem_pkg::amo_op_t           saved_op,
  output logic [mem_pkg::XLEN-1:0]   saved_wdata,
  output logic [mem_pkg::XLEN-1:0]   old_word,
  dbus_if.master                     bus,
  output logic                       done,
  output logic                       fault,
  output logic [mem_pkg::XLEN-1:0]   result
);
  import mem_pkg::*;

  ctrl_state_t state;
  logic        accept;
  logic        is_mem;
  logic        saved_store;

  assign is_mem = is_load || is_store || is_amo;
  assign accept = start && (state == ST_IDLE);  // busy starts are dropped

  // control
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= ST_IDLE;
      fault <= 1'b0;
    end else begin
      fault <= accept && is_mem && access_fault;  // lines up with ST_DONE
      unique case (state)
        ST_IDLE: begin
          if (accept) begin
            if (!is_mem || access_fault) begin
              state <= ST_DONE;
            end else if (is_amo) begin
              state <= ST_AMO_READ;
            end else begin
              state <= ST_ACCESS;
            end
          end
        end
        ST_ACCESS: begin
          if (bus.data_ok) state <= ST_DONE;
        end
        ST_AMO_READ: begin
          if (bus.data_ok) state <= ST_AMO_WRITE;
        end
        ST_AMO_WRITE: begin
          if (bus.data_ok) state <= ST_DONE;
        end
        ST_DONE: state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  // operation registers and result
  always_ff @(posedge clk) begin
    if (accept) begin
      saved_addr     <= addr;
      saved_size     <= is_amo ? SIZE_W : size;         // amo is a word access
      saved_unsigned <= is_amo ? 1'b0 : unsigned_load;  // old word comes back signed
      saved_op       <= amo_op;
      saved_wdata    <= wdata;
      saved_store    <= is_store && !is_amo;
      result         <= addr;   // non-memory, fault and store result
    end

    if (state == ST_ACCESS && bus.data_ok && !saved_store) begin
      result <= load_value;
    end

    if (state == ST_AMO_READ && bus.data_ok) begin
      old_word <= load_value;
    end

    if (state == ST_AMO_WRITE && bus.data_ok) begin
      result <= old_word;
    end
  end

  assign done = (state == ST_DONE);

  // bus request straight from state and the saved operation
  assign bus.valid = (state == ST_ACCESS) || (state == ST_AMO_READ) ||
                     (state == ST_AMO_WRITE);
  assign bus.addr  = saved_addr;
  assign bus.size  = saved_size;

  always_comb begin
    if ((state == ST_ACCESS && saved_store) || state == ST_AMO_WRITE) begin
      bus.strobe = store_strobe;
    end else begin
      bus.strobe = '0;   // read
    end
  end

  // amo write puts the new word in both halves, strobe picks one
  assign bus.wdata = (state == ST_AMO_WRITE) ? {2{amo_new}} : store_data;

endmodule

`default_nettype wire

//--- src/amo_alu.sv
`timescale 1ns/1ps
`default_nettype none

module amo_alu (
  input  mem_pkg::amo_op_t         op,
  input  logic [mem_pkg::XLEN-1:0] old_word,
  input  logic [mem_pkg::XLEN-1:0] operand,
  output logic [31:0]              amo_new
);
  import mem_pkg::*;

  logic [31:0] a;
  logic [31:0] b;
  logic        lt_s;
  logic        lt_u;

  // word amo only
  assign a = old_word[31:0];
  assign b = operand[31:0];

  assign lt_s = $signed(a) < $signed(b);
  assign lt_u = a < b;

  always_comb begin
    unique case (op)
      AMO_SWAP: amo_new = b;
      AMO_ADD:  amo_new = a + b;
      AMO_XOR:  amo_new = a ^ b;
      AMO_AND:  amo_new = a & b;
      AMO_OR:   amo_new = a | b;
      AMO_MIN:  amo_new = lt_s ? a : b;
      AMO_MAX:  amo_new = lt_s ? b : a;
      AMO_MINU: amo_new = lt_u ? a : b;
      AMO_MAXU: amo_new = lt_u ? b : a;
      default:  amo_new = a;  // leave memory unchanged
    endcase
  end

endmodule

`default_nettype wire

//--- src/lane_align.sv
`timescale 1ns/1ps
`default_nettype none

module lane_align (
  input  logic [mem_pkg::XLEN-1:0]   addr,
  input  mem_pkg::mem_size_t         size,
  input  logic [mem_pkg::XLEN-1:0]   wdata,
  input  logic [mem_pkg::XLEN-1:0]   rdata,
  input  logic                       unsigned_load,
  output logic [mem_pkg::STRB_W-1:0] store_strobe,
  output logic [mem_pkg::XLEN-1:0]   store_data,
  output logic [mem_pkg::XLEN-1:0]   load_value
);
  import mem_pkg::*;

  logic [2:0]        offset;
  logic [STRB_W-1:0] size_mask;
  logic [XLEN-1:0]   shifted;

  assign offset = addr[2:0];

  // store side
  always_comb begin
    unique case (size)
      SIZE_B: begin
        size_mask  = 8'h01;
        store_data = {8{wdata[7:0]}};
      end
      SIZE_H: begin
        size_mask  = 8'h03;
        store_data = {4{wdata[15:0]}};
      end
      SIZE_W: begin
        size_mask  = 8'h0f;
        store_data = {2{wdata[31:0]}};
      end
      default: begin
        size_mask  = 8'hff;
        store_data = wdata;
      end
    endcase
  end

  assign store_strobe = size_mask << offset;  // upper lanes fall off

  // load side, bring the addressed lane down to bit 0
  assign shifted = rdata >> {offset, 3'b000};

  always_comb begin
    unique case (size)
      SIZE_B:  load_value = unsigned_load ? {56'b0, shifted[7:0]}
                                          : {{56{shifted[7]}}, shifted[7:0]};
      SIZE_H:  load_value = unsigned_load ? {48'b0, shifted[15:0]}
                                          : {{48{shifted[15]}}, shifted[15:0]};
      SIZE_W:  load_value = unsigned_load ? {32'b0, shifted[31:0]}
                                          : {{32{shifted[31]}}, shifted[31:0]};
      default: load_value = shifted;
    endcase
  end

endmodule

`default_nettype wire

//--- src/pmp_checker.sv
`timescale 1ns/1ps
`default_nettype none

module pmp_checker (
  input  logic [mem_pkg::XLEN-1:0] addr,
  input  logic                     is_write,   // store or amo
  input  logic [7:0]               pmpcfg0,
  input  logic [mem_pkg::XLEN-1:0] pmpaddr0,
  input  logic [1:0]               priv_mode,
  output logic                     access_fault
);
  import mem_pkg::*;

  pmp_mode_t       mode;
  logic [XLEN-1:0] tor_top;
  logic [XLEN-1:0] na4_base;
  logic [XLEN-1:0] napot_base;
  logic            match;
  logic            perm_ok;

  assign mode = pmp_mode_t'(pmpcfg0[4:3]);

  // pmpaddr holds address bits 55..2
  assign tor_top    = {8'b0, pmpaddr0[53:0], 2'b00};
  assign na4_base   = tor_top;
  assign napot_base = {10'b0, pmpaddr0[53:12], 12'b0};  // 4 KiB aligned

  always_comb begin
    unique case (mode)
      PMP_TOR:   match = addr < tor_top;   // base is zero
      PMP_NA4:   match = (addr >= na4_base) && (addr < na4_base + XLEN'(4));
      PMP_NAPOT: match = (addr >= napot_base) &&
                         (addr < napot_base + XLEN'(PMP_NAPOT_BYTES));
      default:   match = 1'b0;
    endcase
  end

  // W bit for writes, R bit otherwise
  assign perm_ok = is_write ? pmpcfg0[1] : pmpcfg0[0];

  always_comb begin
    if (match) begin
      access_fault = !perm_ok;
    end else begin
      // no entry applies, only machine mode gets through
      access_fault = (priv_mode != PRIV_M);
    end
  end

endmodule

`default_nettype wire

//--- src/dbus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dbus_if;
  import mem_pkg::*;

  logic              valid;    // level, held until data_ok
  logic [XLEN-1:0]   addr;
  logic [STRB_W-1:0] strobe;   // all zero means read
  logic [XLEN-1:0]   wdata;
  mem_size_t         size;
  logic              data_ok;  // one cycle pulse from memory
  logic [XLEN-1:0]   rdata;

  modport master (
    output valid, addr, strobe, wdata, size,
    input  data_ok, rdata
  );

  modport port (
    input  valid, addr, strobe, wdata, size,
    output data_ok, rdata
  );

endinterface

`default_nettype wire

//--- src/mem_pkg.sv
`default_nettype none

package mem_pkg;

  localparam int XLEN            = 64;
  localparam int STRB_W          = XLEN / 8;   // one strobe per byte lane
  localparam int PMP_NAPOT_BYTES = 4096;       // fixed napot region
  localparam logic [1:0] PRIV_M  = 2'd3;

  // access width
  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2,
    SIZE_D = 2'd3
  } mem_size_t;

  typedef enum logic [3:0] {
    AMO_SWAP = 4'd0,
    AMO_ADD  = 4'd1,
    AMO_XOR  = 4'd2,
    AMO_AND  = 4'd3,
    AMO_OR   = 4'd4,
    AMO_MIN  = 4'd5,
    AMO_MAX  = 4'd6,
    AMO_MINU = 4'd7,
    AMO_MAXU = 4'd8
  } amo_op_t;

  // address matching mode, pmpcfg A field
  typedef enum logic [1:0] {
    PMP_OFF   = 2'd0,
    PMP_TOR   = 2'd1,
    PMP_NA4   = 2'd2,
    PMP_NAPOT = 2'd3
  } pmp_mode_t;

  typedef enum logic [2:0] {
    ST_IDLE      = 3'd0,
    ST_ACCESS    = 3'd1,  // plain load or store on the bus
    ST_AMO_READ  = 3'd2,
    ST_AMO_WRITE = 3'd3,
    ST_DONE      = 3'd4
  } ctrl_state_t;

endpackage

`default_nettype wire
